// ==== rtl/sa_config.svh ====
/* build-time sizes for the matrix-multiply unit
   include in any file that needs the array size or a word width */

`ifndef SA_CONFIG_SVH
`define SA_CONFIG_SVH

// array side, also the batch length and the number of output banks
`define SA_DIM 8

// weight row select width
`define SA_SEL_W $clog2(`SA_DIM)

`define SA_ACT_W 8      // activations and weights, signed
`define SA_ACC_W 24     // partial sums and stored results, signed

// per-bank address width, 8 bits per bank as in the write controller
`define SA_BANK_AW 8

`endif

// ==== rtl/sa_pkg.sv ====
/* word types shared by the array, the write controller and the banks
   modules import it inside their body, ports use scoped names */

`include "sa_config.svh"

package sa_pkg;

    // one activation or one weight
    typedef logic signed [`SA_ACT_W-1:0] act_t;

    // partial sum moving down a column, also the stored result
    typedef logic signed [`SA_ACC_W-1:0] acc_t;

    // address inside one output bank
    typedef logic [`SA_BANK_AW-1:0] bank_addr_t;

endpackage

// ==== rtl/mac_pe.sv ====
/* one weight-stationary MAC cell of the systolic array
   activation moves right and partial sum moves down through one register each */

`timescale 1ns/1ns
`include "sa_config.svh"

module mac_pe (
    input  logic          clk,
    input  logic          reset,
    input  logic          wt_load,    // latch wt_in as the stationary weight
    input  sa_pkg::act_t  wt_in,
    input  sa_pkg::act_t  act_in,     // from the left neighbour or the skew stage
    input  sa_pkg::acc_t  psum_in,    // from the cell above or zero on the top row
    output sa_pkg::act_t  act_out,
    output sa_pkg::acc_t  psum_out
);
    import sa_pkg::*;

    act_t weight;
    logic signed [2*`SA_ACT_W-1:0] product;

    assign product = weight * act_in;   // full width signed product

    // stationary weight changes only on a row load
    always_ff @(posedge clk) begin
        if (wt_load) begin
            weight <= wt_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            act_out  <= '0;
            psum_out <= '0;
        end else begin
            act_out  <= act_in;
            psum_out <= psum_in + product;   // sign extended to acc_t
        end
    end

endmodule

// ==== rtl/sys_array.sv ====
/* SA_DIM x SA_DIM grid of MAC cells with input skew and output alignment
   also decodes weight row loads and produces the batch timing pulses */

`timescale 1ns/1ns
`include "sa_config.svh"

module sys_array (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wt_load,
    input  logic [`SA_SEL_W-1:0]             wt_sel,        // row to load
    input  sa_pkg::act_t [`SA_DIM-1:0]       wt_row,        // element j goes to column j
    input  logic                             act_valid,
    input  sa_pkg::act_t [`SA_DIM-1:0]       act_row,       // element k goes to row k
    output sa_pkg::acc_t [`SA_DIM-1:0]       col_result,
    output logic                             batch_start,   // first valid cycle of a batch
    output logic                             result_start   // two cycles before the first write
);
    import sa_pkg::*;

    localparam int n = `SA_DIM;
    localparam int out_lat = 2;   // matches the write controller start-up latency

    logic [n-1:0] row_load;
    act_t act_h [n][n+1];     // activation entering column j of row k
    acc_t psum [n+1][n];      // partial sum entering row k of column j
    acc_t out_q [out_lat][n];
    logic [n:0] valid_q;      // act_valid delayed by 1 .. n+1 cycles

    always_comb begin
        for (int k = 0; k < n; k++) begin
            row_load[k] = wt_load && (int'(wt_sel) == k);
        end
    end

    // element k waits k cycles so vector r meets cell (k, j) at t0 + r + k + j
    for (genvar k = 0; k < n; k++) begin : g_skew
        if (k == 0) begin : g_direct
            assign act_h[k][0] = act_row[k];
        end else begin : g_delay
            act_t sk [k];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < k; i++) begin
                        sk[i] <= '0;
                    end
                end else begin
                    sk[0] <= act_row[k];
                    for (int i = 1; i < k; i++) begin
                        sk[i] <= sk[i-1];
                    end
                end
            end

            assign act_h[k][0] = sk[k-1];
        end
    end

    for (genvar j = 0; j < n; j++) begin : g_top
        assign psum[0][j] = '0;
    end

    for (genvar k = 0; k < n; k++) begin : g_row
        for (genvar j = 0; j < n; j++) begin : g_col
            mac_pe pe_i (
                .clk      (clk),
                .reset    (reset),
                .wt_load  (row_load[k]),
                .wt_in    (wt_row[j]),
                .act_in   (act_h[k][j]),
                .psum_in  (psum[k][j]),
                .act_out  (act_h[k][j+1]),
                .psum_out (psum[k+1][j])
            );
        end
    end

    // column j leaves the grid at t0 + r + j + n, the banks write it at + 2
    always_ff @(posedge clk) begin
        for (int j = 0; j < n; j++) begin
            out_q[0][j] <= psum[n][j];
            for (int i = 1; i < out_lat; i++) begin
                out_q[i][j] <= out_q[i-1][j];
            end
        end
    end

    always_comb begin
        for (int j = 0; j < n; j++) begin
            col_result[j] = out_q[out_lat-1][j];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[n-1:0], act_valid};
        end
    end

    assign batch_start  = act_valid & ~valid_q[0];
    assign result_start = valid_q[n-1] & ~valid_q[n];   // rising edge n cycles later

endmodule

// ==== rtl/wr_control.sv ====
/* diagonal write-enable and per-bank address generator for the output banks
   a pulse on active starts one run, done marks the end of the last write */

`timescale 1ns/1ns
`include "sa_config.svh"

module wr_control #(
    parameter int dim = `SA_DIM
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          active,          // starts a run
    input  logic                          sys_arr_active,  // next batch, releases done
    output logic [dim-1:0]                wr_en,           // one enable per bank
    output sa_pkg::bank_addr_t [dim-1:0]  wr_addr,         // one address per bank
    output logic                          done
);
    import sa_pkg::*;

    typedef logic [dim-1:0] en_t;

    localparam en_t en_full = '1;
    localparam en_t en_last = en_t'(1) << (dim - 1);

    logic run, run_c;
    logic draining, drain_c;
    logic shift_out;         // a zero enters at bit 0 this cycle
    en_t wr_en_c;
    bank_addr_t [dim-1:0] wr_addr_c;
    logic done_c;

    always_ff @(posedge clk) begin
        if (reset) begin
            run      <= 1'b0;
            draining <= 1'b0;
            wr_en    <= '0;
            wr_addr  <= '0;
            done     <= 1'b0;
        end else begin
            run      <= run_c;
            draining <= drain_c;
            wr_en    <= wr_en_c;
            wr_addr  <= wr_addr_c;
            done     <= done_c;
        end
    end

    assign shift_out = draining | (wr_en == en_full);

    always_comb begin
        run_c   = run | active;
        drain_c = draining;
        wr_en_c = '0;

        if (run) begin
            // fill from bit 0 until full, then empty from bit 0
            if (shift_out) begin
                wr_en_c = wr_en << 1;
                drain_c = 1'b1;
            end else begin
                wr_en_c = (wr_en << 1) | en_t'(1);
            end

            if (shift_out && wr_en == en_last) begin   // top bank on its last row
                run_c   = active;
                drain_c = 1'b0;
            end
        end
    end

    // each bank counts its own enabled cycles, so row r lands at address r
    always_comb begin
        for (int b = 0; b < dim; b++) begin
            if (wr_en == '0) begin
                wr_addr_c[b] = '0;
            end else begin
                wr_addr_c[b] = wr_addr[b] + bank_addr_t'(wr_en[b]);
            end
        end
    end

    always_comb begin
        done_c = done;
        if (wr_en == en_last) begin
            done_c = 1'b1;
        end
        // a following batch already writing keeps done low
        if (active) begin
            done_c = 1'b0;
        end
        if (sys_arr_active && done) begin
            done_c = 1'b0;
        end
    end

endmodule

// ==== rtl/out_bank.sv ====
/* result memory for one array column
   synchronous write, read data registered one cycle after rd_addr */

`timescale 1ns/1ns
`include "sa_config.svh"

module out_bank (
    input  logic               clk,
    input  logic               wr_en,
    input  sa_pkg::bank_addr_t wr_addr,
    input  sa_pkg::acc_t       wr_data,
    input  sa_pkg::bank_addr_t rd_addr,
    output sa_pkg::acc_t       rd_data
);
    import sa_pkg::*;

    localparam int depth = 1 << `SA_BANK_AW;

    acc_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // same-address read during a write returns the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/mmu_top.sv ====
/* matrix-multiply unit: systolic array, write controller and SA_DIM result banks
   load weights by row, stream one batch, wait for done, read rows by rd_addr */

`timescale 1ns/1ns
`include "sa_config.svh"

module mmu_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wt_load,
    input  logic [`SA_SEL_W-1:0]        wt_sel,
    input  sa_pkg::act_t [`SA_DIM-1:0]  wt_row,
    input  logic                        act_valid,
    input  sa_pkg::act_t [`SA_DIM-1:0]  act_row,
    input  sa_pkg::bank_addr_t          rd_addr,   // shared by every bank
    output sa_pkg::acc_t [`SA_DIM-1:0]  rd_data,   // one product row, column j in word j
    output logic                        done
);
    import sa_pkg::*;

    localparam int n = `SA_DIM;

    acc_t [n-1:0] col_result;
    logic batch_start;
    logic result_start;
    logic [n-1:0] wr_en;
    bank_addr_t [n-1:0] wr_addr;
    acc_t bank_q [n];

    sys_array array_i (
        .clk          (clk),
        .reset        (reset),
        .wt_load      (wt_load),
        .wt_sel       (wt_sel),
        .wt_row       (wt_row),
        .act_valid    (act_valid),
        .act_row      (act_row),
        .col_result   (col_result),
        .batch_start  (batch_start),
        .result_start (result_start)
    );

    wr_control #(
        .dim (n)
    ) wr_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .active         (result_start),
        .sys_arr_active (batch_start),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .done           (done)
    );

    for (genvar j = 0; j < n; j++) begin : g_bank
        out_bank bank_i (
            .clk     (clk),
            .wr_en   (wr_en[j]),
            .wr_addr (wr_addr[j]),
            .wr_data (col_result[j]),
            .rd_addr (rd_addr),
            .rd_data (bank_q[j])
        );
    end

    always_comb begin
        for (int j = 0; j < n; j++) begin
            rd_data[j] = bank_q[j];
        end
    end

endmodule

// ==== sim/mmu_asserts.sv ====
/* concurrent checks on the write controller
   bound into wr_control from the testbench, failures go through $error */

`timescale 1ns/1ns
`include "sa_config.svh"

module mmu_asserts #(
    parameter int dim = `SA_DIM
) (
    input logic           clk,
    input logic           reset,
    input logic [dim-1:0] wr_en,
    input logic           done
);

    // true for all zeros or one unbroken run of ones
    function automatic logic is_run(input logic [dim-1:0] v);
        logic [dim-1:0] low;
        low = v & -v;   // lowest set bit
        return ((v + low) & v) == '0;
    endfunction

    wr_en_contiguous: assert property (
        @(posedge clk) disable iff (reset) is_run(wr_en)
    ) else $error("wr_en is not one contiguous run of ones");

    // done only rises once the top bank has finished
    no_write_when_done: assert property (
        @(posedge clk) disable iff (reset) !(done && (wr_en != '0))
    ) else $error("done is high while a bank write enable is set");

    clear_after_reset: assert property (
        @(posedge clk) reset |=> ((wr_en == '0) && !done)
    ) else $error("wr_en or done not cleared after reset");

endmodule

// ==== sim/mmu_tb.sv ====
/* directed testbench for the matrix-multiply unit
   loads weights by row, streams batches, reads every bank row and compares
   each word with a software model of the product matrix */

`timescale 1ns/1ns
`include "sa_config.svh"

module mmu_tb;
    import sa_pkg::*;

    localparam int n = `SA_DIM;
    localparam int done_limit = 8 * `SA_DIM;   // cycles allowed for any single wait

    logic clk;
    logic reset;
    logic wt_load;
    logic [`SA_SEL_W-1:0] wt_sel;
    act_t [n-1:0] wt_row;
    logic act_valid;
    act_t [n-1:0] act_row;
    bank_addr_t rd_addr;
    acc_t [n-1:0] rd_data;
    logic done;

    logic [31:0] lfsr = 32'h0578_e9de;
    int wt_m [n][n];     // weight at row k and column j
    int act_m [n][n];    // element k of vector r
    time t_first;        // edge that presented vector 0 of the last batch

    mmu_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .wt_load   (wt_load),
        .wt_sel    (wt_sel),
        .wt_row    (wt_row),
        .act_valid (act_valid),
        .act_row   (act_row),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .done      (done)
    );

    bind wr_control mmu_asserts #(.dim(dim)) asserts_i (
        .clk   (clk),
        .reset (reset),
        .wr_en (wr_en),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // right-shift Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int width, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit taken
            val = {val[30:0], lfsr[0]};
        end
    endtask

    // signed dot product of vector r with weight column j
    function automatic longint model_result(input int r, input int j);
        longint sum;
        sum = 0;
        for (int k = 0; k < n; k++) begin
            sum += longint'(act_m[r][k]) * longint'(wt_m[k][j]);
        end
        return sum;
    endfunction

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got !== exp) begin
            $display("ERR at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // polls done at the falling edge until it reaches level
    task automatic wait_done(input logic level, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > done_limit) begin
                $display("timeout at %0t: done did not go to %0d during %s",
                         $time, level, what);
                stop_with_failure();
            end
        end while (done !== level);
    endtask

    task automatic randomize_matrices(input bit new_weights);
        logic [31:0] v;
        for (int a = 0; a < n; a++) begin
            for (int b = 0; b < n; b++) begin
                random_bits(`SA_ACT_W, v);
                act_m[a][b] = int'(act_t'(v[`SA_ACT_W-1:0]));
                if (new_weights) begin
                    random_bits(`SA_ACT_W, v);
                    wt_m[a][b] = int'(act_t'(v[`SA_ACT_W-1:0]));
                end
            end
        end
    endtask

    task automatic load_weights();
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            wt_load <= 1'b1;
            wt_sel  <= k[`SA_SEL_W-1:0];
            for (int j = 0; j < n; j++) begin
                wt_row[j] <= act_t'(wt_m[k][j]);
            end
        end
        @(posedge clk);
        wt_load <= 1'b0;
    endtask

    // count is below n only when the batch is cut by reset
    task automatic stream_batch(input int count);
        for (int r = 0; r < count; r++) begin
            @(posedge clk);
            if (r == 0) begin
                t_first = $time;
            end
            act_valid <= 1'b1;
            for (int k = 0; k < n; k++) begin
                act_row[k] <= act_t'(act_m[r][k]);
            end
        end
        @(posedge clk);
        act_valid <= 1'b0;
        act_row   <= '0;
    endtask

    task automatic read_and_check(input string tag);
        acc_t got;
        for (int r = 0; r < n; r++) begin
            @(posedge clk);
            rd_addr <= bank_addr_t'(r);
            @(posedge clk);   // bank samples rd_addr here
            @(negedge clk);
            for (int j = 0; j < n; j++) begin
                got = rd_data[j];
                check_value($sformatf("%s row %0d col %0d", tag, r, j), got,
                            model_result(r, j));
            end
        end
    endtask

    task automatic run_batch(input string tag);
        load_weights();
        stream_batch(n);
        wait_done(1'b1, tag);
        read_and_check(tag);
    endtask

    task automatic identity_weights();
        longint cycles;
        for (int k = 0; k < n; k++) begin
            for (int j = 0; j < n; j++) begin
                wt_m[k][j] = (k == j) ? 1 : 0;
            end
        end
        randomize_matrices(1'b0);
        load_weights();
        stream_batch(n);
        wait_done(1'b1, "identity batch");
        cycles = longint'((($time - t_first) - 10) / 20);
        check_value("cycles from first vector to done", cycles, 3 * n + 1);
        read_and_check("identity");
    endtask

    task automatic full_random_batch();
        randomize_matrices(1'b1);
        run_batch("random");
    endtask

    task automatic fill_constant(input int value);
        for (int a = 0; a < n; a++) begin
            for (int b = 0; b < n; b++) begin
                wt_m[a][b]  = value;
                act_m[a][b] = value;
            end
        end
    endtask

    task automatic extreme_values();
        fill_constant(-128);
        run_batch("all -128");
        fill_constant(127);
        run_batch("all 127");
    endtask

    task automatic back_to_back_batches();
        randomize_matrices(1'b1);
        run_batch("first batch");
        check_value("done before second batch", done, 1);
        randomize_matrices(1'b0);   // same weights with new activations
        stream_batch(n);
        @(negedge clk);   // batch_start has already released done
        check_value("done after second batch start", done, 0);
        wait_done(1'b1, "second batch");
        read_and_check("second batch");
    endtask

    task automatic reset_mid_batch();
        randomize_matrices(1'b1);
        load_weights();
        stream_batch(n / 2);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < 3 * n; c++) begin   // the cut batch never completes
            @(negedge clk);
            check_value("done after reset", done, 0);
        end
        randomize_matrices(1'b1);
        run_batch("after reset");
    endtask

    initial begin
        reset     = 1'b1;
        wt_load   = 1'b0;
        wt_sel    = '0;
        wt_row    = '0;
        act_valid = 1'b0;
        act_row   = '0;
        rd_addr   = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        identity_weights();
        full_random_batch();
        extreme_values();
        back_to_back_batches();
        reset_mid_batch();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/sa_pkg.sv
rtl/mac_pe.sv
rtl/sys_array.sv
rtl/wr_control.sv
rtl/out_bank.sv
rtl/mmu_top.sv
sim/mmu_asserts.sv
sim/mmu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := mmu_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/sa_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation finished cleanly, see $(LOG)"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
